// ==== sm510_lite.f ====
sm510_pkg.sv
sm510_divider.sv
sm510_ram.sv
sm510_lcd_strobe.sv
sm510_sequencer.sv
sm510_exec.sv
sm510_top.sv
tb_sm510.sv

// ==== tb_sm510.sv ====
`default_nettype none

module tb_sm510;
  timeunit 1ns;
  timeprecision 100ps;
  import sm510_pkg::*;

  localparam logic [11:0] RESET_ADDR = {2'd3, 4'd7, 6'd0};  // 3_7_00
  localparam logic [11:0] HALT_ADDR  = {2'd1, 4'd0, 6'd0};  // 1_0_00
  // 4 x 70k steps, two clocks per step
  localparam int MAX_CYCLES = 2 * 4 * 70000;

  logic        clk;
  logic        reset;
  logic        clk_en;
  logic [7:0]  rom_data;
  logic [11:0] rom_addr;
  logic [3:0]  input_k;
  logic [1:0]  output_lcd_h_index;
  logic [7:0]  output_shifter_s;
  lcd_frame_t  segment;
  logic        segment_bs;
  logic [3:0]  output_r;

  logic [7:0]  rom [4096];  // Program memory model
  logic [11:0] cursor;      // Next address to load
  int          errors;
  int          checks;
  int          test_errs;    // Error count when the test began
  int          cycles;
  int          seed;

  sm510_top dut_i (
    .clk(clk), .reset(reset), .clk_en(clk_en), .rom_data(rom_data), .rom_addr(rom_addr),
    .input_k(input_k), .output_lcd_h_index(output_lcd_h_index),
    .output_shifter_s(output_shifter_s), .segment(segment), .segment_bs(segment_bs),
    .output_r(output_r)
  );

  always #4 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Run exceeded the cycle limit of %0d", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Pl polynomial step, bank and page unchanged
  function automatic logic [11:0] next_addr(input logic [11:0] a);
    return {a[11:6], a[0] == a[1], a[5:1]};
  endfunction

  // ROM presents the byte at the pre-step address after each step
  task automatic step();
    logic [11:0] fetch_addr;
    @(negedge clk);
    clk_en     = 1'b1;
    fetch_addr = rom_addr;
    @(negedge clk);
    clk_en   = 1'b0;
    rom_data = rom[fetch_addr];
  endtask

  task automatic steps(input int n);
    repeat (n) step();
  endtask

  task automatic emit(input logic [7:0] b);
    rom[cursor] = b;
    cursor      = next_addr(cursor);
  endtask

  task automatic reset_dut();
    for (int i = 0; i < 4096; i++) rom[i] = 8'h00;  // All SKIP
    cursor = RESET_ADDR;
    @(negedge clk);
    reset    = 1'b1;
    clk_en   = 1'b0;
    input_k  = '0;
    rom_data = '0;
    repeat (4) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Step until rom_addr hits target, bounded
  task automatic step_until_addr(input logic [11:0] target, input int limit);
    int n;
    n = 0;
    while (rom_addr !== target && n < limit) begin
      step();
      n++;
    end
    if (rom_addr !== target) begin
      $display("rom_addr never reached %0h within %0d steps", target, limit);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("%-16s %s (%0d errors)", name, errors == test_errs ? "ok" : "FAILED",
             errors - test_errs);
    test_errs = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_fetch();
    logic [11:0] exp;
    reset_dut();
    exp = RESET_ADDR;
    check_value("rom_addr", exp, rom_addr);
    for (int i = 0; i < 10; i++) begin
      steps(2);  // LOAD_PC, DECODE of a SKIP
      exp = next_addr(exp);
      check_value("rom_addr", exp, rom_addr);
    end
    end_test("fetch");
  endtask

  task automatic test_arith();
    logic [3:0] a, b, c, d, e, f;
    a = 4'($urandom % 8);
    b = 4'($urandom % 8);
    c = 4'(8 + $urandom % 8);  // c+d always carries
    d = 4'(8 + $urandom % 8);
    e = 4'($urandom);
    f = e ^ 4'h5;
    reset_dut();
    emit(8'h20 | a);  // LAX a
    emit(8'h30 | b);  // ADX b
    emit(8'h61);      // ATR
    emit(8'h20 | c);
    emit(8'h30 | d);
    emit(8'h61);      // Skipped by carry
    emit(8'h61);
    steps(6);
    check_value("output_r", 4'(a + b), output_r);
    steps(6);
    check_value("output_r", 4'(a + b), output_r);  // ATR after carry dropped
    steps(2);
    check_value("output_r", 4'(c + d), output_r);
    // Second LAX of a chain is skipped
    reset_dut();
    emit(8'h20 | e);
    emit(8'h20 | f);
    emit(8'h61);
    steps(6);
    check_value("output_r", e, output_r);
    end_test("arith");
  endtask

  task automatic test_shifter();
    reset_dut();
    emit(8'h63);  // WS
    emit(8'h62);  // WR
    emit(8'h63);
    steps(2);
    check_value("output_shifter_s", 8'h01, output_shifter_s);
    steps(2);
    check_value("output_shifter_s", 8'h02, output_shifter_s);
    steps(2);
    check_value("output_shifter_s", 8'h05, output_shifter_s);
    end_test("shifter");
  endtask

  task automatic test_jumps();
    logic [11:0] tl_dest, call_dest, ret_addr;
    tl_dest   = {2'd1, 4'd2, 6'h05};  // TL 72 45
    call_dest = {2'd2, 4'd1, 6'h03};  // TML 7D 83
    reset_dut();
    emit(8'h72);
    emit(8'h45);
    cursor = tl_dest;
    emit(8'h7D);
    emit(8'h83);
    ret_addr = cursor;
    emit(8'h63);     // WS marks the return
    cursor = call_dest;
    emit(8'h6E);     // RTN0
    steps(4);
    check_value("rom_addr", tl_dest, rom_addr);
    steps(4);
    check_value("rom_addr", call_dest, rom_addr);
    steps(2);
    check_value("rom_addr", ret_addr, rom_addr);
    steps(2);
    check_value("output_shifter_s", 8'h01, output_shifter_s);
    end_test("jumps");
  endtask

  task automatic test_lcd();
    logic [3:0] v, w, m;
    logic [1:0] h_old;
    int         n;
    v = 4'($urandom);
    w = 4'($urandom);
    m = 4'($urandom);
    reset_dut();
    emit(OP_LBL);
    emit(8'h63);      // Row 6 column 3
    emit(8'h20 | v);
    emit(8'h11);      // EXC 1, writes v and moves to row 7
    emit(8'h20 | w);
    emit(8'h10);      // EXC, writes w
    emit(8'h20 | m);
    emit(8'h59);      // ATL
    steps(16);
    check_value("segment_bs", m[output_lcd_h_index], segment_bs);
    for (int p = 0; p < 6; p++) begin
      h_old = output_lcd_h_index;
      n = 0;
      while (output_lcd_h_index == h_old && n < 40) begin
        step();
        n++;
      end
      if (n >= 40) begin
        $display("LCD common index did not advance within 40 steps");
        errors++;
      end
      check_value("output_lcd_h_index", 2'(h_old + 1), output_lcd_h_index);
      check_value("segment.seg_a[3]", v[output_lcd_h_index], segment.seg_a[3]);
      check_value("segment.seg_b[3]", w[output_lcd_h_index], segment.seg_b[3]);
      check_value("segment_bs", m[output_lcd_h_index], segment_bs);
    end
    end_test("lcd");
  endtask

  task automatic test_halt();
    reset_dut();
    emit(OP_CEND);
    cursor = HALT_ADDR;
    emit(8'h63);  // WS runs after wake
    step_until_addr(HALT_ADDR, 10);
    for (int i = 0; i < 20; i++) begin
      step();
      check_value("rom_addr", HALT_ADDR, rom_addr);  // Parked in HALT
    end
    input_k = 4'h2;
    step_until_addr(next_addr(HALT_ADDR), 10);
    input_k = '0;
    step();
    check_value("output_shifter_s", 8'h01, output_shifter_s);
    end_test("halt");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    clk_en    = 1'b0;
    rom_data  = '0;
    input_k   = '0;
    errors    = 0;
    checks    = 0;
    test_errs = 0;
    cycles    = 0;
    seed      = $urandom(57);  // Fixed seed for immediates
    test_fetch();
    test_arith();
    test_shifter();
    test_jumps();
    test_lcd();
    test_halt();
    $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sm510_top.sv ====
`default_nettype none

module sm510_top (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             clk_en,      // 32.768 kHz step strobe
  input  logic [sm510_pkg::OPCODE_W-1:0]   rom_data,
  output logic [sm510_pkg::ROM_ADDR_W-1:0] rom_addr,
  input  logic [sm510_pkg::NIBBLE_W-1:0]   input_k,     // K1-4
  output logic [sm510_pkg::H_W-1:0]        output_lcd_h_index,
  output logic [sm510_pkg::SHIFT_W-1:0]    output_shifter_s,
  output sm510_pkg::lcd_frame_t            segment,
  output logic                             segment_bs,
  output logic [sm510_pkg::NIBBLE_W-1:0]   output_r
);
  import sm510_pkg::*;

  div_ticks_t          ticks;
  stage_t              stage;
  pc_t                 pc;
  ram_req_t            ram_req;
  logic [NIBBLE_W-1:0] ram_rd;
  lcd_frame_t          next_frame;
  logic [H_W-1:0]      next_h;      // Common gathered ahead of the strobe
  logic [NIBBLE_W-1:0] segment_l;
  logic                halt_req;
  logic                skip_next;
  logic                lax_chain;
  logic                div_clear;

  assign rom_addr = pc;

  sm510_divider div_i (
    .clk(clk), .reset(reset), .clk_en(clk_en), .div_clear(div_clear), .ticks(ticks)
  );

  sm510_ram ram_i (
    .clk(clk), .req(ram_req), .rd_data(ram_rd), .lcd_h(next_h), .frame(next_frame)
  );

  sm510_lcd_strobe lcd_i (
    .clk(clk), .reset(reset), .clk_en(clk_en), .f_1khz(ticks.f_1khz),
    .next_frame(next_frame), .segment_l(segment_l), .h_index(output_lcd_h_index),
    .next_h(next_h), .segment(segment), .segment_bs(segment_bs)
  );

  sm510_sequencer seq_i (
    .clk(clk), .reset(reset), .clk_en(clk_en), .opcode(rom_data),
    .halt_req(halt_req), .skip_next(skip_next), .lax_chain(lax_chain),
    .tick_1s(ticks.tick_1s), .input_k(input_k), .stage(stage)
  );

  sm510_exec exec_i (
    .clk(clk), .reset(reset), .clk_en(clk_en), .stage(stage), .opcode(rom_data),
    .ram_rd(ram_rd), .input_k(input_k), .ram_req(ram_req), .pc(pc),
    .halt_req(halt_req), .skip_next(skip_next), .lax_chain(lax_chain),
    .div_clear(div_clear), .segment_l(segment_l), .shifter_w(output_shifter_s),
    .output_r(output_r)
  );

endmodule

`default_nettype wire

// ==== sm510_exec.sv ====
`default_nettype none

module sm510_exec (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clk_en,
  input  sm510_pkg::stage_t              stage,
  input  logic [sm510_pkg::OPCODE_W-1:0] opcode,
  input  logic [sm510_pkg::NIBBLE_W-1:0] ram_rd,
  input  logic [sm510_pkg::NIBBLE_W-1:0] input_k,
  output sm510_pkg::ram_req_t            ram_req,
  output sm510_pkg::pc_t                 pc,
  output logic                           halt_req,
  output logic                           skip_next,
  output logic                           lax_chain,
  output logic                           div_clear,
  output logic [sm510_pkg::NIBBLE_W-1:0] segment_l,
  output logic [sm510_pkg::SHIFT_W-1:0]  shifter_w,
  output logic [sm510_pkg::NIBBLE_W-1:0] output_r
);
  import sm510_pkg::*;

  logic [NIBBLE_W-1:0] acc;
  logic                carry;
  ram_addr_t           b;            // Bm:Bl
  pc_t                 stack_s;      // Top of stack
  pc_t                 stack_r;
  logic [OPCODE_W-1:0] last_opcode;  // First byte of a two-byte op
  pc_t                 pc_inc;
  logic [NIBBLE_W:0]   adx_sum;      // Carry out in MSB
  logic [NIBBLE_W:0]   add11_sum;
  logic                is_lax;

  // Polynomial step, Pu and Pm stay put
  always_comb begin
    pc_inc    = pc;
    pc_inc.pl = {pc.pl[0] == pc.pl[1], pc.pl[5:1]};
  end

  assign adx_sum   = {1'b0, acc} + {1'b0, opcode[3:0]};
  assign add11_sum = {1'b0, acc} + {1'b0, ram_rd} + {{NIBBLE_W{1'b0}}, carry};
  assign is_lax    = opcode[7:4] == OP_GRP_LAX;

  // EXC writes Acc back during its decode step
  assign ram_req.addr    = b;
  assign ram_req.wr_data = acc;
  assign ram_req.wren    = clk_en && stage == STAGE_DECODE && opcode[7:2] == OP_EXC;

  ////////////////////////////////////////////////////////////////////////////
  // Architectural state

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= PC_RESET_VECTOR;
      stack_s     <= '0;
      stack_r     <= '0;
      acc         <= '0;
      carry       <= 1'b0;
      b           <= '0;
      last_opcode <= '0;
      halt_req    <= 1'b0;
      skip_next   <= 1'b0;
      lax_chain   <= 1'b0;
      div_clear   <= 1'b0;
      segment_l   <= '0;
      shifter_w   <= '0;
      output_r    <= '0;
    end else if (clk_en) begin
      div_clear <= 1'b0;  // Single-step pulse

      if (stage == STAGE_LOAD_PC || stage == STAGE_PERF_2) begin
        pc <= pc_inc;  // Jumps below override
      end

      case (stage)
        STAGE_LOAD_PC: begin
          skip_next <= 1'b0;
          lax_chain <= lax_chain && is_lax;  // Chain holds through skipped LAX
        end
        STAGE_HALT: begin
          pc       <= PC_HALT_VECTOR;  // Resume point after wake
          halt_req <= 1'b0;
        end
        STAGE_DECODE: begin
          last_opcode <= opcode;
          casez (opcode)
            8'h08: acc <= acc + ram_rd;  // ADD
            8'h09: begin                 // ADD11, skip on carry
              {carry, acc} <= add11_sum;
              skip_next    <= add11_sum[NIBBLE_W];
            end
            8'h0A: acc <= ~acc;          // COMA
            {OP_EXC, 2'b??}: begin       // EXC x
              acc        <= ram_rd;
              b.bm[1:0]  <= b.bm[1:0] ^ opcode[1:0];
            end
            {OP_LDA, 2'b??}: begin       // LDA x
              acc        <= ram_rd;
              b.bm[1:0]  <= b.bm[1:0] ^ opcode[1:0];
            end
            {OP_GRP_LAX, 4'b????}: begin
              acc       <= opcode[3:0];
              lax_chain <= 1'b1;         // Following LAX gets skipped
            end
            8'h3?: begin                 // ADX x, carry flag untouched
              acc       <= adx_sum[NIBBLE_W-1:0];
              skip_next <= adx_sum[NIBBLE_W];
            end
            8'h53: skip_next <= acc == ram_rd;  // TAM
            8'h59: segment_l <= acc;            // ATL
            OP_CEND: halt_req <= 1'b1;
            8'h61: output_r  <= acc;            // ATR
            8'h62: shifter_w <= {shifter_w[SHIFT_W-2:0], 1'b0};  // WR
            8'h63: shifter_w <= {shifter_w[SHIFT_W-2:0], 1'b1};  // WS
            8'h65: div_clear <= 1'b1;           // IDIV
            8'h66: carry     <= 1'b0;           // RC
            8'h67: carry     <= 1'b1;           // SC
            8'h6A: acc       <= input_k;        // KTA
            8'h6E: begin                        // RTN0, pop
              pc      <= stack_s;
              stack_s <= stack_r;
            end
            {OP_GRP_T, 6'b??????}: pc.pl <= opcode[5:0];  // T xy
            default: begin
              // SKIP, LBL and TL/TML first bytes do nothing here
            end
          endcase
        end
        STAGE_PERF_2: begin
          // opcode now holds the second byte
          if (last_opcode == OP_LBL) begin
            b <= '{bm: opcode[6:4], bl: opcode[3:0]};
          end else if (last_opcode[7:4] == OP_GRP_TL) begin
            if (last_opcode[3:0] < 4'hB) begin  // TL, long jump
              pc <= '{pu: opcode[7:6], pm: last_opcode[3:0], pl: opcode[5:0]};
            end else if (last_opcode[3:0] >= 4'hC) begin  // TML, long call
              stack_r <= stack_s;
              stack_s <= pc_inc;  // Return past the second byte
              pc      <= '{pu: opcode[7:6], pm: {2'b00, last_opcode[1:0]}, pl: opcode[5:0]};
            end
          end
        end
        default: begin
          // LOAD_2 and SKIP leave state alone
        end
      endcase
    end
  end

  // A RAM write ends a one-byte instruction
  assert property (@(posedge clk) disable iff (reset) ram_req.wren |=> stage == STAGE_LOAD_PC);

endmodule

`default_nettype wire

// ==== sm510_sequencer.sv ====
`default_nettype none

module sm510_sequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clk_en,
  input  logic [sm510_pkg::OPCODE_W-1:0] opcode,
  input  logic                           halt_req,
  input  logic                           skip_next,
  input  logic                           lax_chain,
  input  logic                           tick_1s,
  input  logic [sm510_pkg::NIBBLE_W-1:0] input_k,
  output sm510_pkg::stage_t              stage
);
  import sm510_pkg::*;

  logic wake;         // Registered wake source
  logic is_two_byte;  // LBL xy, TL/TML xyz
  logic is_lax;

  assign is_two_byte = opcode == OP_LBL || opcode[7:4] == OP_GRP_TL;
  assign is_lax      = opcode[7:4] == OP_GRP_LAX;

  always_ff @(posedge clk) begin
    if (reset) begin
      wake <= 1'b0;
    end else if (clk_en) begin
      wake <= tick_1s || input_k != '0;  // Seen one step later
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      stage <= STAGE_LOAD_PC;
    end else if (clk_en) begin
      case (stage)
        STAGE_LOAD_PC: begin
          if (halt_req) begin
            stage <= STAGE_HALT;
          end else if (skip_next || (lax_chain && is_lax)) begin
            stage <= STAGE_SKIP;  // Drop this instruction
          end else begin
            stage <= STAGE_DECODE;
          end
        end
        STAGE_DECODE: stage <= is_two_byte ? STAGE_LOAD_2 : STAGE_LOAD_PC;
        STAGE_LOAD_2: stage <= STAGE_PERF_2;
        STAGE_HALT:   stage <= wake ? STAGE_LOAD_PC : STAGE_HALT;
        default:      stage <= STAGE_LOAD_PC;  // PERF_2 and SKIP
      endcase
    end
  end

  // Exec never asks for a halt and a skip on the same fetch
  assert property (@(posedge clk) disable iff (reset)
    clk_en && stage == STAGE_LOAD_PC |-> !(halt_req && skip_next));

endmodule

`default_nettype wire

// ==== sm510_lcd_strobe.sv ====
`default_nettype none

module sm510_lcd_strobe (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           clk_en,
  input  logic                           f_1khz,
  input  sm510_pkg::lcd_frame_t          next_frame,  // Gathered for next_h
  input  logic [sm510_pkg::NIBBLE_W-1:0] segment_l,
  output logic [sm510_pkg::H_W-1:0]      h_index,
  output logic [sm510_pkg::H_W-1:0]      next_h,
  output sm510_pkg::lcd_frame_t          segment,
  output logic                           segment_bs
);
  import sm510_pkg::*;

  logic                   f_prev;    // f_1khz one step ago
  logic                   strobe;    // Rising edge
  logic [LCD_COMMONS-1:0] h_onehot;

  assign strobe = f_1khz & ~f_prev;

  always_ff @(posedge clk) begin
    if (reset) begin
      f_prev  <= 1'b0;
      h_index <= '0;
      segment <= '0;
    end else if (clk_en) begin
      f_prev <= f_1khz;
      if (strobe) begin
        segment <= next_frame;  // Frame for the common we move to
        h_index <= next_h;
      end
    end
  end

  assign next_h = h_index + H_W'(1);

  // BS pulses while the active common's L bit is set
  assign h_onehot   = LCD_COMMONS'(1) << h_index;
  assign segment_bs = |(segment_l & h_onehot);

endmodule

`default_nettype wire

// ==== sm510_ram.sv ====
`default_nettype none

module sm510_ram (
  input  logic                           clk,
  input  sm510_pkg::ram_req_t            req,
  output logic [sm510_pkg::NIBBLE_W-1:0] rd_data,
  input  logic [sm510_pkg::H_W-1:0]      lcd_h,    // Bit to gather
  output sm510_pkg::lcd_frame_t          frame
);
  import sm510_pkg::*;

  logic [NIBBLE_W-1:0] mem [RAM_DEPTH];  // Bm:Bl addressed nibbles

  ////////////////////////////////////////////////////////////////////////////
  // CPU port

  always_ff @(posedge clk) begin
    if (req.wren) begin
      mem[req.addr] <= req.wr_data;
    end
  end

  assign rd_data = mem[req.addr];  // Same-step read

  ////////////////////////////////////////////////////////////////////////////
  // LCD gather port

  // One bit per column, picked by the common about to be strobed
  always_comb begin
    for (int col = 0; col < SEG_W; col++) begin
      frame.seg_a[col] = mem[{LCD_ROW_A, 4'(col)}][lcd_h];
      frame.seg_b[col] = mem[{LCD_ROW_B, 4'(col)}][lcd_h];
    end
  end

endmodule

`default_nettype wire

// ==== sm510_divider.sv ====
`default_nettype none

module sm510_divider (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clk_en,
  input  logic                  div_clear,  // IDIV pulse
  output sm510_pkg::div_ticks_t ticks
);
  import sm510_pkg::*;

  logic [DIV_W-1:0] count;  // One count per step
  logic             wrap;   // Last count before rollover

  assign wrap = &count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (clk_en) begin
      if (div_clear) begin
        count <= '0;  // Clear wins over counting
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // A forced clear is not a one-second wrap
  assign ticks.tick_1s = wrap & ~div_clear;
  assign ticks.f_1khz  = count[KHZ_BIT];  // 32-step period
  assign ticks.count   = count;

  // A held clear would starve the wake tick
  assert property (@(posedge clk) disable iff (reset) clk_en && div_clear |=> !div_clear);

endmodule

`default_nettype wire

// ==== sm510_pkg.sv ====
`default_nettype none

package sm510_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int NIBBLE_W    = 4;
  localparam int OPCODE_W    = 8;
  localparam int ROM_ADDR_W  = 12;
  localparam int DIV_W       = 15;   // 32.768 kHz steps down to 1 Hz
  localparam int SEG_W       = 16;   // Columns per LCD segment row
  localparam int SHIFT_W     = 8;    // S1-8 strobe shifter
  localparam int RAM_DEPTH   = 128;
  localparam int LCD_COMMONS = 4;
  localparam int H_W         = $clog2(LCD_COMMONS);
  localparam int KHZ_BIT     = 4;    // Divider bit for the LCD strobe

  // Display memory rows
  localparam logic [2:0] LCD_ROW_A = 3'd6;
  localparam logic [2:0] LCD_ROW_B = 3'd7;

  ////////////////////////////////////////////////////////////////////////////
  // Bundles

  typedef struct packed {
    logic [1:0] pu;  // Bank
    logic [3:0] pm;  // Page
    logic [5:0] pl;  // Polynomial step within page
  } pc_t;

  typedef struct packed {
    logic [2:0] bm;  // Row
    logic [3:0] bl;  // Column
  } ram_addr_t;

  typedef struct packed {
    ram_addr_t             addr;
    logic                  wren;
    logic [NIBBLE_W-1:0]   wr_data;
  } ram_req_t;

  typedef struct packed {
    logic [SEG_W-1:0] seg_a;  // From row 6
    logic [SEG_W-1:0] seg_b;  // From row 7
  } lcd_frame_t;

  typedef struct packed {
    logic             tick_1s;  // Wrap step
    logic             f_1khz;
    logic [DIV_W-1:0] count;
  } div_ticks_t;

  typedef enum logic [2:0] {
    STAGE_LOAD_PC,
    STAGE_DECODE,
    STAGE_LOAD_2,
    STAGE_PERF_2,
    STAGE_HALT,
    STAGE_SKIP
  } stage_t;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes and vectors

  localparam logic [OPCODE_W-1:0] OP_LBL  = 8'h5F;  // LBL xy, two bytes
  localparam logic [OPCODE_W-1:0] OP_CEND = 8'h5D;  // Stop clock
  localparam logic [3:0] OP_GRP_LAX = 4'h2;         // 2x
  localparam logic [3:0] OP_GRP_TL  = 4'h7;         // 7x, TL/TML
  localparam logic [1:0] OP_GRP_T   = 2'b10;        // 80-BF
  localparam logic [5:0] OP_EXC     = 6'b0001_00;   // 10-13
  localparam logic [5:0] OP_LDA     = 6'b0001_10;   // 18-1B

  localparam pc_t PC_RESET_VECTOR = '{pu: 2'd3, pm: 4'd7, pl: 6'd0};  // 3_7_00
  localparam pc_t PC_HALT_VECTOR  = '{pu: 2'd1, pm: 4'd0, pl: 6'd0};  // 1_0_00

endpackage

`default_nettype wire
